// File: design/uart_pkg.sv
////////////////////////////////////////////////////////////////////////////
// UART shared definitions
// Register map, line control layout, line configuration and the
// received-frame record passed from the deserializer to the slave
////////////////////////////////////////////////////////////////////////////

package uart_pkg;

    // Word addresses seen on wb_adr_i[3:2]
    typedef enum logic [1:0] {
        REG_DATA = 2'd0,
        REG_LCR  = 2'd1,
        REG_LSR  = 2'd2,
        REG_DIV  = 2'd3
    } reg_addr_e;

    // Line control register, bit 0 is rx_en
    typedef struct packed {
        logic       loopback;
        logic [1:0] reserved;
        logic       even_parity;
        logic       parity_en;
        logic       dual_stop;
        logic       tx_en;
        logic       rx_en;
    } lcr_t;

    // Everything the serializer and deserializer need to frame a character
    typedef struct packed {
        logic [31:0] divisor;
        lcr_t        lcr;
    } line_cfg_t;

    // One received character with its status
    typedef struct packed {
        logic [7:0] data;
        logic       err_framing;
        logic       err_parity;
        logic       parity_bit;
    } rx_frame_t;

endpackage

// File: design/uart_regs.sv
////////////////////////////////////////////////////////////////////////////
// UART register slave
// Wishbone decode and ack, LCR/DIV/LSR storage and all bus-driven FIFO
// pushes and pops
////////////////////////////////////////////////////////////////////////////

module uart_regs import uart_pkg::*; #(
    parameter int unsigned DEFAULT_DIV = 16
) (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  reg_addr_e   wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    input  logic        wb_we_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_stb_i,
    output logic        wb_ack_o,
    input  logic        txf_full_i,
    output logic        txf_push_o,
    output logic [7:0]  txf_data_o,
    input  logic        rxf_empty_i,
    input  logic [7:0]  rxf_data_i,
    output logic        rxf_push_o,
    output logic        rxf_pop_o,
    input  rx_frame_t   frame_i,
    input  logic        frame_valid_i,
    output line_cfg_t   cfg_o
);

    lcr_t        lcr_q;
    logic [31:0] div_q;
    logic        err_framing_q;
    logic        err_parity_q;
    logic        parity_bit_q;
    logic        bus_wr;
    logic        bus_rd;

    // Ack one cycle after strobe, never two in a row
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_stb_i & ~wb_ack_o;
        end
    end

    // Side effects only in the ack cycle
    assign bus_wr = wb_stb_i & wb_we_i & wb_ack_o;
    assign bus_rd = wb_stb_i & ~wb_we_i & wb_ack_o;

    //////////////////////////////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            lcr_q <= lcr_t'(8'h03);
            div_q <= 32'(DEFAULT_DIV);
        end else if (bus_wr) begin
            if (wb_adr_i == REG_LCR && wb_sel_i[0]) begin
                lcr_q <= lcr_t'(wb_dat_i[7:0]);
            end
            if (wb_adr_i == REG_DIV) begin
                for (int i = 0; i < 4; i++) begin
                    if (wb_sel_i[i]) begin
                        div_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
                    end
                end
            end
        end
    end

    // Status of the last frame, kept even when rx is disabled
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            err_framing_q <= 1'b0;
            err_parity_q  <= 1'b0;
            parity_bit_q  <= 1'b0;
        end else if (frame_valid_i) begin
            err_framing_q <= frame_i.err_framing;
            err_parity_q  <= frame_i.err_parity;
            parity_bit_q  <= frame_i.parity_bit;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // FIFO strobes and read mux
    //////////////////////////////////////////////////////////////////////////

    assign txf_push_o = bus_wr & (wb_adr_i == REG_DATA) & wb_sel_i[0] & ~txf_full_i;
    assign txf_data_o = wb_dat_i[7:0];
    assign rxf_pop_o  = bus_rd & (wb_adr_i == REG_DATA) & ~rxf_empty_i;
    assign rxf_push_o = frame_valid_i & lcr_q.rx_en;

    assign cfg_o = '{divisor: div_q, lcr: lcr_q};

    always_comb begin
        case (wb_adr_i)
            REG_DATA: wb_dat_o = {24'd0, rxf_data_i};
            REG_LCR:  wb_dat_o = {24'd0, lcr_q};
            REG_LSR:  wb_dat_o = {27'd0, parity_bit_q, err_parity_q, err_framing_q,
                                  ~txf_full_i, ~rxf_empty_i};
            default:  wb_dat_o = div_q;
        endcase
    end

endmodule

// File: design/uart_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Byte FIFO
// Circular buffer with combinational head and full/empty flags
////////////////////////////////////////////////////////////////////////////

module uart_fifo #(
    parameter int unsigned DEPTH = 4
) (
    input  logic       wb_clk_i,
    input  logic       wb_rst_i,
    input  logic       push_i,
    input  logic       pop_i,
    input  logic [7:0] data_i,
    output logic [7:0] data_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [7:0]  mem [DEPTH];
    logic [AW-1:0] wptr_q;
    logic [AW-1:0] rptr_q;
    logic [AW:0]   count_q;
    logic          do_push;
    logic          do_pop;

    assign full_o  = (count_q == (AW+1)'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign data_o  = mem[rptr_q];

    always_ff @(posedge wb_clk_i) begin
        if (do_push) begin
            mem[wptr_q] <= data_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (do_pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
            // Push and pop together leave the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// File: design/uart_tx.sv
////////////////////////////////////////////////////////////////////////////
// UART transmit serializer
// Pops the TX FIFO and shifts out start, data, parity and stop bits
////////////////////////////////////////////////////////////////////////////

module uart_tx import uart_pkg::*; (
    input  logic       wb_clk_i,
    input  logic       wb_rst_i,
    input  line_cfg_t  cfg_i,
    input  logic       fifo_empty_i,
    input  logic [7:0] fifo_data_i,
    output logic       fifo_pop_o,
    output logic       tx_o
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    tx_state_e   state_q;
    logic [31:0] period;
    logic [31:0] cnt_q;
    logic        bit_done;
    logic [2:0]  bit_idx_q;
    logic        stop_idx_q;
    logic [7:0]  shift_q;
    logic        parity_q;

    // Divisor of zero behaves like one
    assign period   = (cfg_i.divisor == 32'd0) ? 32'd1 : cfg_i.divisor;
    assign bit_done = (cnt_q == period - 32'd1);

    assign fifo_pop_o = (state_q == TX_IDLE) & cfg_i.lcr.tx_en & ~fifo_empty_i;

    // Shift register and running parity
    always_ff @(posedge wb_clk_i) begin
        if (fifo_pop_o) begin
            shift_q  <= fifo_data_i;
            parity_q <= ~cfg_i.lcr.even_parity;
        end else if (bit_done && (state_q == TX_START || state_q == TX_DATA)) begin
            shift_q  <= shift_q >> 1;
            parity_q <= parity_q ^ shift_q[0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q    <= TX_IDLE;
            tx_o       <= 1'b1;
            cnt_q      <= '0;
            bit_idx_q  <= '0;
            stop_idx_q <= 1'b0;
        end else begin
            cnt_q <= bit_done ? 32'd0 : cnt_q + 32'd1;
            case (state_q)
                TX_IDLE: begin
                    cnt_q <= '0;
                    tx_o  <= 1'b1;
                    if (fifo_pop_o) begin
                        tx_o    <= 1'b0;
                        state_q <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        tx_o      <= shift_q[0];
                        bit_idx_q <= '0;
                        state_q   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q != 3'd7) begin
                            tx_o <= shift_q[0];
                        end else if (cfg_i.lcr.parity_en) begin
                            tx_o    <= parity_q;
                            state_q <= TX_PARITY;
                        end else begin
                            tx_o       <= 1'b1;
                            stop_idx_q <= 1'b0;
                            state_q    <= TX_STOP;
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_done) begin
                        tx_o       <= 1'b1;
                        stop_idx_q <= 1'b0;
                        state_q    <= TX_STOP;
                    end
                end
                default: begin
                    // Second stop bit only with dual_stop
                    if (bit_done) begin
                        if (cfg_i.lcr.dual_stop && !stop_idx_q) begin
                            stop_idx_q <= 1'b1;
                        end else begin
                            state_q <= TX_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: design/uart_rx.sv
////////////////////////////////////////////////////////////////////////////
// UART receive deserializer
// Synchronizes the line, finds the start bit, samples mid-bit and checks
// parity and the first stop bit
////////////////////////////////////////////////////////////////////////////

module uart_rx import uart_pkg::*; (
    input  logic      wb_clk_i,
    input  logic      wb_rst_i,
    input  line_cfg_t cfg_i,
    input  logic      rx_i,
    input  logic      loop_i,
    output rx_frame_t frame_o,
    output logic      frame_valid_o
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    rx_state_e   state_q;
    logic [1:0]  sync_q;
    logic        rx_s;
    logic [31:0] period;
    logic [31:0] half;
    logic [31:0] cnt_q;
    logic        bit_done;
    logic        half_done;
    logic        start_ok;
    logic [2:0]  bit_idx_q;
    logic        parity_q;

    assign rx_s      = sync_q[1];
    assign period    = (cfg_i.divisor == 32'd0) ? 32'd1 : cfg_i.divisor;
    assign half      = {1'b0, period[31:1]};
    assign bit_done  = (cnt_q == period - 32'd1);
    assign half_done = (half == 32'd0) || (cnt_q == half - 32'd1);
    // Start still low half a bit later
    assign start_ok  = (state_q == RX_START) & half_done & ~rx_s;

    //////////////////////////////////////////////////////////////////////////
    // Frame datapath
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (start_ok) begin
            parity_q           <= ~cfg_i.lcr.even_parity;
            frame_o.err_parity <= 1'b0;
            frame_o.parity_bit <= 1'b0;
        end else if (bit_done) begin
            case (state_q)
                RX_DATA: begin
                    frame_o.data <= {rx_s, frame_o.data[7:1]};
                    parity_q     <= parity_q ^ rx_s;
                end
                RX_PARITY: begin
                    frame_o.parity_bit <= rx_s;
                    frame_o.err_parity <= parity_q ^ rx_s;
                end
                RX_STOP: begin
                    frame_o.err_framing <= ~rx_s;
                end
                default: begin
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sync_q        <= 2'b11;
            state_q       <= RX_IDLE;
            cnt_q         <= '0;
            bit_idx_q     <= '0;
            frame_valid_o <= 1'b0;
        end else begin
            sync_q        <= {sync_q[0], cfg_i.lcr.loopback ? loop_i : rx_i};
            frame_valid_o <= 1'b0;
            cnt_q         <= bit_done ? 32'd0 : cnt_q + 32'd1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (!rx_s) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_done) begin
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                        // Glitch shorter than half a bit goes back to idle
                        state_q   <= start_ok ? RX_DATA : RX_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 32'd1;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= cfg_i.lcr.parity_en ? RX_PARITY : RX_STOP;
                        end
                    end
                end
                RX_PARITY: begin
                    if (bit_done) begin
                        state_q <= RX_STOP;
                    end
                end
                default: begin
                    if (bit_done) begin
                        frame_valid_o <= 1'b1;
                        state_q       <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/uart_top.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone UART top level
// Register slave, TX and RX FIFOs, serializer and deserializer
////////////////////////////////////////////////////////////////////////////

module uart_top import uart_pkg::*; #(
    parameter int unsigned FIFO_DEPTH  = 4,
    parameter int unsigned DEFAULT_DIV = 16
) (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic [3:2]  wb_adr_i,
    output logic [31:0] wb_dat_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_we_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_stb_i,
    output logic        wb_ack_o,
    input  logic        rx_i,
    output logic        tx_o
);

    line_cfg_t  cfg;
    rx_frame_t  frame;
    logic       frame_valid;
    logic       txf_push;
    logic       txf_pop;
    logic [7:0] txf_wdata;
    logic [7:0] txf_head;
    logic       txf_full;
    logic       txf_empty;
    logic       rxf_push;
    logic       rxf_pop;
    logic [7:0] rxf_head;
    logic       rxf_empty;

    uart_regs #(
        .DEFAULT_DIV (DEFAULT_DIV)
    ) regs0 (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .wb_adr_i      (reg_addr_e'(wb_adr_i)),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_we_i       (wb_we_i),
        .wb_sel_i      (wb_sel_i),
        .wb_stb_i      (wb_stb_i),
        .wb_ack_o      (wb_ack_o),
        .txf_full_i    (txf_full),
        .txf_push_o    (txf_push),
        .txf_data_o    (txf_wdata),
        .rxf_empty_i   (rxf_empty),
        .rxf_data_i    (rxf_head),
        .rxf_push_o    (rxf_push),
        .rxf_pop_o     (rxf_pop),
        .frame_i       (frame),
        .frame_valid_i (frame_valid),
        .cfg_o         (cfg)
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH)) txf0 (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .push_i   (txf_push),
        .pop_i    (txf_pop),
        .data_i   (txf_wdata),
        .data_o   (txf_head),
        .full_o   (txf_full),
        .empty_o  (txf_empty)
    );

    // Bytes that arrive while full are dropped by the FIFO itself
    uart_fifo #(.DEPTH(FIFO_DEPTH)) rxf0 (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .push_i   (rxf_push),
        .pop_i    (rxf_pop),
        .data_i   (frame.data),
        .data_o   (rxf_head),
        .full_o   (),
        .empty_o  (rxf_empty)
    );

    uart_tx tx0 (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .cfg_i        (cfg),
        .fifo_empty_i (txf_empty),
        .fifo_data_i  (txf_head),
        .fifo_pop_o   (txf_pop),
        .tx_o         (tx_o)
    );

    uart_rx rx0 (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .cfg_i         (cfg),
        .rx_i          (rx_i),
        .loop_i        (tx_o),
        .frame_o       (frame),
        .frame_valid_o (frame_valid)
    );

endmodule

// File: bench/uart_tb.sv
////////////////////////////////////////////////////////////////////////////
// UART testbench
// Directed tests over Wishbone and the serial pins, with a serial driver
// and monitor and an LFSR for data bytes
////////////////////////////////////////////////////////////////////////////

module uart_tb import uart_pkg::*;;

    localparam int BIT_CYCLES = 16;
    // About 5000 cycles of tests, so this only trips on a hang
    localparam int MAX_CYCLES = 40000;

    logic        wb_clk;
    logic        wb_rst;
    logic [3:2]  wb_adr;
    logic [31:0] wb_dat;
    logic [31:0] wb_dat_o;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic        wb_stb;
    logic        wb_ack;
    logic        rx_i;
    logic        tx_o;
    logic [31:0] lfsr;
    int          errors;
    int          cycles;

    uart_top #(
        .FIFO_DEPTH  (4),
        .DEFAULT_DIV (16)
    ) dut0 (
        .wb_clk_i (wb_clk),
        .wb_rst_i (wb_rst),
        .wb_adr_i (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat),
        .wb_we_i  (wb_we),
        .wb_sel_i (wb_sel),
        .wb_stb_i (wb_stb),
        .wb_ack_o (wb_ack),
        .rx_i     (rx_i),
        .tx_o     (tx_o)
    );

    initial begin
        wb_clk = 1'b0;
        forever #5 wb_clk = ~wb_clk;
    end

    always @(posedge wb_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = next_lfsr(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        errors++;
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic wb_write(input reg_addr_e addr, input logic [31:0] data,
                            input logic [3:0] sel);
        int waited;
        wb_adr = addr;
        wb_dat = data;
        wb_sel = sel;
        wb_we  = 1'b1;
        wb_stb = 1'b1;
        waited = 1;
        @(negedge wb_clk);
        while (!wb_ack) begin
            @(negedge wb_clk);
            waited++;
        end
        if (waited != 1) report_mismatch("write ack delay", 32'h1, 32'(waited));
        // Strobe held over the ack cycle's closing edge
        @(negedge wb_clk);
        if (wb_ack !== 1'b0) report_mismatch("write ack width", 32'h0, 32'(wb_ack));
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input reg_addr_e addr, output logic [31:0] data);
        int waited;
        wb_adr = addr;
        wb_sel = 4'hf;
        wb_we  = 1'b0;
        wb_stb = 1'b1;
        waited = 1;
        @(negedge wb_clk);
        while (!wb_ack) begin
            @(negedge wb_clk);
            waited++;
        end
        if (waited != 1) report_mismatch("read ack delay", 32'h1, 32'(waited));
        data = wb_dat_o;
        @(negedge wb_clk);
        if (wb_ack !== 1'b0) report_mismatch("read ack width", 32'h0, 32'(wb_ack));
        wb_stb = 1'b0;
    endtask

    task automatic drive_bit(input logic b);
        rx_i = b;
        repeat (BIT_CYCLES) @(negedge wb_clk);
    endtask

    task automatic serial_send(input logic [7:0] data, input logic par_en,
                               input logic even, input logic bad_stop,
                               input logic bad_par, output logic par_sent);
        par_sent = even ? ^data : ~^data;
        if (bad_par) begin
            par_sent = ~par_sent;
        end
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        if (par_en) begin
            drive_bit(par_sent);
        end
        drive_bit(~bad_stop);
        // Two idle bits between frames
        drive_bit(1'b1);
        drive_bit(1'b1);
    endtask

    task automatic serial_capture(input string name, input logic [7:0] exp_data,
                                  input logic par_en, input logic even,
                                  input logic two_stop);
        int         wait_cnt;
        logic [7:0] got;
        logic       exp_par;
        wait_cnt = 0;
        while (tx_o !== 1'b0 && wait_cnt < 64) begin
            @(negedge wb_clk);
            wait_cnt++;
        end
        if (tx_o !== 1'b0) begin
            $display("No start bit seen on tx_o in %s", name);
            errors++;
            return;
        end
        // Move to the middle of the start bit
        repeat (BIT_CYCLES / 2) @(negedge wb_clk);
        if (tx_o !== 1'b0) begin
            report_mismatch({name, " start"}, 32'h0, 32'(tx_o));
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge wb_clk);
            got[i] = tx_o;
        end
        if (got !== exp_data) begin
            report_mismatch({name, " data"}, 32'(exp_data), 32'(got));
        end
        if (par_en) begin
            exp_par = even ? ^exp_data : ~^exp_data;
            repeat (BIT_CYCLES) @(negedge wb_clk);
            if (tx_o !== exp_par) begin
                report_mismatch({name, " parity"}, 32'(exp_par), 32'(tx_o));
            end
        end
        for (int i = 0; i < (two_stop ? 2 : 1); i++) begin
            repeat (BIT_CYCLES) @(negedge wb_clk);
            if (tx_o !== 1'b1) begin
                report_mismatch({name, " stop"}, 32'h1, 32'(tx_o));
            end
        end
    endtask

    task automatic wait_rx_ready(input string name, output logic [31:0] lsr);
        int polls;
        polls = 0;
        wb_read(REG_LSR, lsr);
        while (lsr[0] !== 1'b1 && polls < 200) begin
            wb_read(REG_LSR, lsr);
            polls++;
        end
        if (lsr[0] !== 1'b1) begin
            $display("No received byte showed up in LSR during %s", name);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        logic [31:0] rd;
        wb_read(REG_LCR, rd);
        if (rd !== 32'h3) report_mismatch("reset LCR", 32'h3, rd);
        wb_read(REG_DIV, rd);
        if (rd !== 32'd16) report_mismatch("reset DIV", 32'd16, rd);
        wb_read(REG_LSR, rd);
        if (rd !== 32'h2) report_mismatch("reset LSR", 32'h2, rd);
    endtask

    task automatic test_div_lanes();
        logic [31:0] rd;
        wb_write(REG_DIV, 32'h11223344, 4'b0101);
        wb_read(REG_DIV, rd);
        if (rd !== 32'h00220044) report_mismatch("DIV lanes", 32'h00220044, rd);
        wb_write(REG_DIV, 32'd16, 4'hf);
        wb_read(REG_DIV, rd);
        if (rd !== 32'd16) report_mismatch("DIV restore", 32'd16, rd);
    endtask

    task automatic transmit_mode(input string name, input logic [7:0] lcr);
        logic [7:0] b;
        wb_write(REG_LCR, 32'(lcr), 4'h1);
        for (int i = 0; i < 3; i++) begin
            random_byte(b);
            wb_write(REG_DATA, 32'(b), 4'h1);
            serial_capture(name, b, lcr[3], lcr[4], lcr[2]);
            // Let the last stop bit finish
            repeat (BIT_CYCLES) @(negedge wb_clk);
        end
    endtask

    task automatic test_loopback();
        logic [7:0]  sent [4];
        logic [31:0] lsr;
        logic [31:0] rd;
        wb_write(REG_LCR, 32'h83, 4'h1);
        for (int i = 0; i < 4; i++) begin
            random_byte(sent[i]);
            wb_write(REG_DATA, 32'(sent[i]), 4'h1);
        end
        for (int i = 0; i < 4; i++) begin
            wait_rx_ready("loopback", lsr);
            if (lsr[3:2] !== 2'b00) report_mismatch("loopback LSR errors", 32'h0,
                                                    32'(lsr[3:2]));
            wb_read(REG_DATA, rd);
            if (rd !== 32'(sent[i])) report_mismatch("loopback data", 32'(sent[i]), rd);
        end
        wb_write(REG_LCR, 32'h03, 4'h1);
    endtask

    task automatic test_rx_errors();
        logic [7:0]  b;
        logic        par;
        logic [31:0] lsr;
        logic [31:0] rd;
        // Stop bit forced low
        random_byte(b);
        serial_send(b, 1'b0, 1'b0, 1'b1, 1'b0, par);
        wait_rx_ready("framing error", lsr);
        if (lsr[2] !== 1'b1) report_mismatch("framing LSR bit 2", 32'h1, 32'(lsr[2]));
        wb_read(REG_DATA, rd);
        if (rd !== 32'(b)) report_mismatch("framing data", 32'(b), rd);
        // Even parity with the parity bit flipped
        wb_write(REG_LCR, 32'h1b, 4'h1);
        random_byte(b);
        serial_send(b, 1'b1, 1'b1, 1'b0, 1'b1, par);
        wait_rx_ready("parity error", lsr);
        if (lsr[3] !== 1'b1) report_mismatch("parity LSR bit 3", 32'h1, 32'(lsr[3]));
        if (lsr[4] !== par) report_mismatch("parity LSR bit 4", 32'(par), 32'(lsr[4]));
        if (lsr[2] !== 1'b0) report_mismatch("parity LSR bit 2", 32'h0, 32'(lsr[2]));
        wb_read(REG_DATA, rd);
        if (rd !== 32'(b)) report_mismatch("parity data", 32'(b), rd);
        wb_write(REG_LCR, 32'h03, 4'h1);
    endtask

    task automatic test_rx_overflow();
        logic [7:0]  sent [6];
        logic        par;
        logic [31:0] rd;
        for (int i = 0; i < 6; i++) begin
            random_byte(sent[i]);
            serial_send(sent[i], 1'b0, 1'b0, 1'b0, 1'b0, par);
        end
        // Only the first four fit in the FIFO
        for (int i = 0; i < 4; i++) begin
            wb_read(REG_DATA, rd);
            if (rd !== 32'(sent[i])) report_mismatch("overflow data", 32'(sent[i]), rd);
        end
        wb_read(REG_LSR, rd);
        if (rd[0] !== 1'b0) report_mismatch("overflow LSR bit 0", 32'h0, 32'(rd[0]));
    endtask

    initial begin
        wb_rst = 1'b1;
        wb_adr = 2'd0;
        wb_dat = 32'd0;
        wb_we  = 1'b0;
        wb_sel = 4'h0;
        wb_stb = 1'b0;
        rx_i   = 1'b1;
        lfsr   = 32'h6f0b;
        errors = 0;
        repeat (4) @(negedge wb_clk);
        wb_rst = 1'b0;
        @(negedge wb_clk);

        test_reset_values();
        test_div_lanes();
        transmit_mode("tx 8N1", 8'h03);
        transmit_mode("tx 8E2", 8'h1f);
        transmit_mode("tx 8O1", 8'h0b);
        test_loopback();
        test_rx_errors();
        test_rx_overflow();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
design/uart_pkg.sv
design/uart_regs.sv
design/uart_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
bench/uart_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator
verilator --binary --timing --top-module uart_tb -f verilog.f -o uart_sim > build.log 2>&1 &&
./obj_dir/uart_sim > sim.log 2>&1 ||
{ echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
